//--- compile.f
source/lease_pkg.sv
source/lfsr_9b.sv
source/priority_encoder.sv
source/lease_lookup_table.sv
source/lease_probability_controller.sv
source/lease_policy_controller.sv
dv/lease_policy_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lease_policy_tb \
	-f compile.f -o lease_policy_sim || exit 1
out="$(./obj_dir/lease_policy_sim 2>&1)"
echo "$out"
echo "$out" | grep -q "TEST OK" && exit 0 || exit 1

//--- dv/lease_policy_tb.sv
/* testbench for the lease policy controller, stimulus tasks, a small
   lease model for expected values and the output assertions */
`timescale 1ns/10ps

module lease_policy_tb
	import lease_pkg::*;
;
	localparam int CAP     = 8;
	localparam int ENTRIES = 4;
	localparam int CAP_BW  = $clog2(CAP);
	localparam int LLT_BW  = $clog2(ENTRIES) + TABLE_SEL_BW;
	localparam logic [WORD_ADDR_BW-1:0] TABLE_REF = 30'h0001_2340; // only address in the table

	logic                    clock_i, resetn_i;
	logic                    con_wren_i, llt_wren_i;
	logic [LLT_BW-1:0]       llt_addr_i;
	logic [31:0]             llt_data_i;
	logic [WORD_ADDR_BW-1:0] llt_search_addr_i;
	logic [CAP_BW-1:0]       cache_addr_i;
	logic                    hit_i, miss_i;
	logic                    done_o, swap_o, expired_o, expired_multi_o, default_o;
	logic [CAP_BW-1:0]       addr_o;

	// expected values, set by the stimulus tasks
	logic              before_strobe;
	logic              exp_swap, exp_default, exp_expired, exp_multi, any_addr;
	logic [CAP_BW-1:0] exp_addr;
	int                lease_model [CAP]; // expected lease counter per line
	int                fill_count;        // lines handed out during cold start
	logic [31:0]       rng_state;

	lease_policy_controller #(
		.CACHE_BLOCK_CAPACITY (CAP),
		.LLT_ENTRIES          (ENTRIES)
	) dut (.*);

	initial begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i; // 4 ns period
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// random reference address that misses the table
	function automatic logic [WORD_ADDR_BW-1:0] fresh_addr();
		logic [WORD_ADDR_BW-1:0] a;
		a = TABLE_REF;
		while (a == TABLE_REF) begin
			rng_state = xorshift32(rng_state);
			a = rng_state[WORD_ADDR_BW-1:0];
		end
		return a;
	endfunction

	// lease model
	// ------------------------------------------------------------
	task automatic age_model();
		for (int i = 0; i < CAP; i++) begin
			if (lease_model[i] != 0) lease_model[i]--; // expired lines stay at zero
		end
	endtask

	task automatic predict_replacement();
		int zeros;
		zeros       = 0;
		exp_expired = 1'b0;
		exp_multi   = 1'b0;
		any_addr    = 1'b0;
		if (fill_count < CAP) begin
			exp_addr = CAP_BW'(fill_count); // cold start, lines in order
			fill_count++;
		end else begin
			for (int i = CAP - 1; i >= 0; i--) begin
				if (lease_model[i] == 0) begin
					zeros++;
					exp_addr = CAP_BW'(i); // ends on the lowest one
				end
			end
			exp_expired = (zeros > 0);
			exp_multi   = (zeros > 1);
			any_addr    = (zeros == 0); // random line, only the range is known
		end
	endtask

	// stimulus, every task starts and ends on a falling edge
	// ------------------------------------------------------------
	task automatic write_default(input int lease);
		con_wren_i = 1'b1;
		llt_addr_i = '0;
		llt_data_i = 32'(lease);
		@(negedge clock_i);
		con_wren_i = 1'b0;
	endtask

	task automatic write_table(input table_field_e field, input int entry,
			input logic [31:0] data);
		llt_wren_i = 1'b1;
		llt_addr_i = {field, 2'(entry)};
		llt_data_i = data;
		@(negedge clock_i);
		llt_wren_i = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done_o && cycles < 20) begin
			@(negedge clock_i);
			cycles++;
		end
		if (!done_o) report_error("timeout, done_o did not rise after a miss");
	endtask

	task automatic do_hit(input logic [WORD_ADDR_BW-1:0] ref_addr, input logic [CAP_BW-1:0] line,
			input int lease, input logic dflt, input logic fill);
		if (!fill) age_model(); // the fill hit does not age
		lease_model[line] = lease;
		exp_default       = dflt && !fill;
		llt_search_addr_i = ref_addr;
		cache_addr_i      = line;
		hit_i             = 1'b1;
		before_strobe     = 1'b0;
		@(negedge clock_i);
		hit_i = 1'b0;
		@(negedge clock_i);
	endtask

	task automatic do_miss(input logic [WORD_ADDR_BW-1:0] ref_addr, input int lease,
			input logic dflt);
		logic [CAP_BW-1:0] line;
		age_model();
		exp_swap    = (lease != 0);
		exp_default = dflt;
		if (exp_swap) predict_replacement();
		llt_search_addr_i = ref_addr;
		miss_i            = 1'b1;
		before_strobe     = 1'b0;
		@(negedge clock_i);
		miss_i = 1'b0;
		wait_done();
		repeat (2) @(negedge clock_i); // let the checks sample before expectations move
		if (exp_swap) begin
			line = addr_o; // cache places the block where the policy says
			do_hit(ref_addr, line, lease, dflt, 1'b1);
		end
	endtask

	// checks
	// ------------------------------------------------------------
	quiet_after_reset: assert property (@(posedge clock_i) disable iff (!resetn_i)
		before_strobe |-> !(done_o || swap_o || expired_o || expired_multi_o || default_o)
			&& (addr_o == '0))
		else report_error($sformatf("mismatch at %0t: output active before the first strobe", $time));

	miss_one_cycle: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$past(miss_i) |-> (swap_o == exp_swap) && (done_o == !exp_swap)
			&& (default_o == (exp_default && !exp_swap)))
		else report_error($sformatf(
			"mismatch at %0t: swap %0b done %0b default %0b one cycle after miss",
			$time, $sampled(swap_o), $sampled(done_o), $sampled(default_o)));

	alloc_flags: assert property (@(posedge clock_i) disable iff (!resetn_i)
		($past(miss_i, 2) && exp_swap) |-> done_o && (default_o == exp_default)
			&& (expired_o == exp_expired) && (expired_multi_o == exp_multi))
		else report_error($sformatf("mismatch at %0t: done %0b default %0b expired %0b multi %0b",
			$time, $sampled(done_o), $sampled(default_o), $sampled(expired_o),
			$sampled(expired_multi_o)));

	alloc_addr: assert property (@(posedge clock_i) disable iff (!resetn_i)
		($past(miss_i, 2) && exp_swap) |-> !$isunknown(addr_o) && (any_addr || addr_o == exp_addr))
		else report_error($sformatf("mismatch at %0t: addr_o %0d, expected %0d",
			$time, $sampled(addr_o), exp_addr));

	hit_default: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$past(hit_i) |-> (default_o == exp_default))
		else report_error($sformatf("mismatch at %0t: default_o %0b after hit, expected %0b",
			$time, $sampled(default_o), exp_default));

	initial begin
		resetn_i          = 1'b0;
		con_wren_i        = 1'b0;
		llt_wren_i        = 1'b0;
		llt_addr_i        = '0;
		llt_data_i        = '0;
		llt_search_addr_i = '0;
		cache_addr_i      = '0;
		hit_i             = 1'b0;
		miss_i            = 1'b0;
		before_strobe     = 1'b1;
		{exp_swap, exp_default, exp_expired, exp_multi, any_addr} = '0;
		exp_addr          = '0;
		fill_count        = 0;
		rng_state         = 32'h6464dc3b;
		for (int i = 0; i < CAP; i++) lease_model[i] = 0;
		repeat (2) @(negedge clock_i);
		resetn_i = 1'b1;
		repeat (4) @(negedge clock_i); // idle, outputs stay low

		write_default(3); // cold start fills lines 0..7
		for (int i = 0; i < CAP; i++) do_miss(fresh_addr(), 3, 1'b1);

		write_default(0); // zero lease, block bypasses the cache
		do_miss(fresh_addr(), 0, 1'b1);

		write_table(fld_ref_addr, 0, 32'(TABLE_REF));
		write_table(fld_lease0, 0, 32'd5);
		write_table(fld_lease1, 0, 32'd7);
		write_table(fld_prob, 0, 32'd256); // always lease0
		do_hit(TABLE_REF, 3'd2, 5, 1'b0, 1'b0);
		do_miss(TABLE_REF, 5, 1'b0);

		write_default(1); // leases of 1, most lines expire together
		for (int i = 0; i < CAP; i++) do_hit(fresh_addr(), CAP_BW'(i), 1, 1'b1, 1'b0);
		do_miss(fresh_addr(), 1, 1'b1);

		write_default(100); // only line 3 runs out
		for (int i = 0; i < CAP; i++) do_hit(fresh_addr(), CAP_BW'(i), 100, 1'b1, 1'b0);
		write_default(1);
		do_hit(fresh_addr(), 3'd3, 1, 1'b1, 1'b0);
		do_miss(fresh_addr(), 1, 1'b1);

		write_default(100); // nothing expired, backup LFSR picks
		for (int i = 0; i < CAP; i++) do_hit(fresh_addr(), CAP_BW'(i), 100, 1'b1, 1'b0);
		do_miss(fresh_addr(), 100, 1'b1);

		repeat (2) @(negedge clock_i);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- source/lease_policy_controller.sv
/* lease replacement policy top, per-line lease counters, default lease,
   cold-start fill, expiry and random replacement, policy FSM */
`timescale 1ns/10ps

module lease_policy_controller
	import lease_pkg::*;
#(
	parameter int  CACHE_BLOCK_CAPACITY = 8, // lines, power of two
	parameter int  LLT_ENTRIES          = 4, // table entries, power of two
	localparam int CAP_BW               = $clog2(CACHE_BLOCK_CAPACITY),
	localparam int LLT_ADDR_BW          = $clog2(LLT_ENTRIES) + TABLE_SEL_BW
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,

	// table and default lease configuration
	input  logic                    con_wren_i,        // config write, addr 0 = default lease
	input  logic                    llt_wren_i,        // table write
	input  logic [LLT_ADDR_BW-1:0]  llt_addr_i,
	input  logic [31:0]             llt_data_i,
	input  logic [WORD_ADDR_BW-1:0] llt_search_addr_i, // current reference address

	// cache side
	input  logic [CAP_BW-1:0]       cache_addr_i,      // line that was hit
	input  logic                    hit_i,             // one-cycle strobe
	input  logic                    miss_i,            // one-cycle strobe
	output logic                    done_o,            // level, held until next miss
	output logic [CAP_BW-1:0]       addr_o,            // replacement line
	output logic                    swap_o,            // missed block gets a line
	output logic                    expired_o,         // replaced line had expired
	output logic                    expired_multi_o,   // more than one line expired
	output logic                    default_o          // default lease was used
);

	// lookup table and lease selector
	// ------------------------------------------------------------
	logic                      tbl_hit;
	logic [LEASE_VALUE_BW-1:0] tbl_lease0, tbl_lease1, sel_lease;
	logic [PERCENT_BW-1:0]     tbl_prob;
	logic                      prob_step; // one pulse per serviced strobe

	lease_lookup_table #(
		.LLT_ENTRIES   (LLT_ENTRIES)
	) llt (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.addr_i        (llt_addr_i),
		.wren_i        (llt_wren_i),
		.data_i        (llt_data_i),
		.search_addr_i (llt_search_addr_i),
		.hit_o         (tbl_hit),
		.lease0_o      (tbl_lease0),
		.lease1_o      (tbl_lease1),
		.lease0_prob_o (tbl_prob)
	);

	lease_probability_controller sel (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.enable_i      (prob_step),
		.lease0_i      (tbl_lease0),
		.lease1_i      (tbl_lease1),
		.lease0_prob_i (tbl_prob),
		.lease_o       (sel_lease)
	);

	// default lease register
	logic [LEASE_VALUE_BW-1:0] default_lease_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && (llt_addr_i == '0)) begin
			default_lease_q <= llt_data_i[LEASE_VALUE_BW-1:0];
		end
	end

	// lease for the current reference, table first then default
	logic [LEASE_VALUE_BW-1:0] ref_lease;
	logic                      alloc;

	assign ref_lease = tbl_hit ? sel_lease : default_lease_q;
	assign alloc     = (ref_lease != '0); // zero lease means bypass the cache

	// counters, expiry flags and replacement sources
	// ------------------------------------------------------------
	logic [LEASE_VALUE_BW-1:0]       lease_cnt_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] expired_flags;
	logic [CAP_BW-1:0]               exp_low, exp_high;
	logic [8:0]                      backup_val;
	logic                            backup_step;

	always_comb begin
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			expired_flags[i] = (lease_cnt_q[i] == '0);
		end
	end

	priority_encoder #(
		.DIRECTION  (0),
		.INPUT_SIZE (CACHE_BLOCK_CAPACITY)
	) enc_low (
		.encoding_i (expired_flags),
		.binary_o   (exp_low)
	);

	priority_encoder #(
		.DIRECTION  (1),
		.INPUT_SIZE (CACHE_BLOCK_CAPACITY)
	) enc_high ( // only tells if several lines expired
		.encoding_i (expired_flags),
		.binary_o   (exp_high)
	);

	lfsr_9b #(
		.SEED     (9'h155)
	) backup_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (backup_step),
		.result_o (backup_val)
	);

	// policy FSM
	// ------------------------------------------------------------
	policy_state_e             state_q;
	logic [CAP_BW-1:0]         cold_cnt_q;     // next line during cold start
	logic                      full_q;         // every line filled once
	logic                      fill_pending_q; // next hit is the fill of a miss
	logic                      miss_default_q; // allocating miss used the default
	logic [LEASE_VALUE_BW-1:0] lease_saved_q;

	// lease for the upcoming fill hit
	always_ff @(posedge clock_i) begin
		if ((state_q == st_normal) && miss_i && alloc) begin
			lease_saved_q <= ref_lease;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= st_normal;
			done_o          <= 1'b0;
			addr_o          <= '0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			prob_step       <= 1'b0;
			backup_step     <= 1'b0;
			cold_cnt_q      <= '0;
			full_q          <= 1'b0;
			fill_pending_q  <= 1'b0;
			miss_default_q  <= 1'b0;
			for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
				lease_cnt_q[j] <= '0;
			end
		end else begin
			// pulses
			prob_step       <= 1'b0;
			backup_step     <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;

			case (state_q)
				st_normal: begin
					// aging on every miss and every hit except the fill hit
					if ((hit_i && !fill_pending_q) || miss_i) begin
						for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
							if (lease_cnt_q[j] != '0) begin
								lease_cnt_q[j] <= lease_cnt_q[j] - 1'b1;
							end
						end
					end

					if (hit_i) begin
						prob_step <= 1'b1;
						if (fill_pending_q) begin
							fill_pending_q            <= 1'b0;
							lease_cnt_q[cache_addr_i] <= lease_saved_q; // line just filled
						end else begin
							lease_cnt_q[cache_addr_i] <= ref_lease; // renew, overrides aging
							default_o                 <= !tbl_hit;
						end
					end else if (miss_i) begin
						prob_step <= 1'b1;
						if (alloc) begin
							state_q        <= st_gen_addr;
							done_o         <= 1'b0;
							swap_o         <= 1'b1;
							fill_pending_q <= 1'b1;
							miss_default_q <= !tbl_hit; // reported with done_o
						end else begin
							done_o    <= 1'b1; // bypass, nothing to replace
							swap_o    <= 1'b0;
							default_o <= !tbl_hit;
						end
					end
				end

				st_gen_addr: begin
					state_q   <= st_normal;
					done_o    <= 1'b1;
					default_o <= miss_default_q;

					if (!full_q) begin
						// cold start, lines in order
						addr_o     <= cold_cnt_q;
						cold_cnt_q <= cold_cnt_q + 1'b1;
						if (&cold_cnt_q) begin
							full_q <= 1'b1;
						end
					end else if (|expired_flags) begin
						addr_o          <= exp_low; // lowest expired line
						expired_o       <= 1'b1;
						expired_multi_o <= (exp_low != exp_high);
					end else begin
						addr_o      <= backup_val[CAP_BW:1]; // nothing expired, random line
						backup_step <= 1'b1;
					end
				end

				default: state_q <= st_normal;
			endcase
		end
	end

	// strobe contract of the cache side
	// ------------------------------------------------------------
	strobe_exclusive: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i));

	no_strobe_in_gen: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(state_q == st_gen_addr) |-> !(hit_i || miss_i));

endmodule

//--- source/lease_probability_controller.sv
/* lease selector, picks lease0 or lease1 by comparing the lease0
   probability against a registered LFSR value */
`timescale 1ns/10ps

module lease_probability_controller
	import lease_pkg::*;
(
	input  logic                      clock_i,
	input  logic                      resetn_i,
	input  logic                      enable_i,      // step the random source
	input  logic [LEASE_VALUE_BW-1:0] lease0_i,      // preferred lease
	input  logic [LEASE_VALUE_BW-1:0] lease1_i,      // alternate lease
	input  logic [PERCENT_BW-1:0]     lease0_prob_i, // 0..256
	output logic [LEASE_VALUE_BW-1:0] lease_o
);

	logic [PERCENT_BW-1:0] rand_val;
	logic [PERCENT_BW-1:0] rand_cmp;

	lfsr_9b #(
		.SEED     (9'h0b5)
	) prob_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (enable_i),
		.result_o (rand_val)
	);

	// only the low 8 bits take part, range 0..255
	// so 256 always picks lease0 and 0 never does
	assign rand_cmp = {1'b0, rand_val[PERCENT_BW-2:0]};

	assign lease_o = (rand_cmp < lease0_prob_i) ? lease0_i : lease1_i;

endmodule

//--- source/lease_lookup_table.sv
/* lease lookup table, per entry a reference address, two leases and a
   lease0 probability, written by field and searched in parallel */
`timescale 1ns/10ps

module lease_lookup_table
	import lease_pkg::*;
#(
	parameter int  LLT_ENTRIES = 4, // power of two
	localparam int ENTRY_BW    = $clog2(LLT_ENTRIES),
	localparam int ADDR_BW     = ENTRY_BW + TABLE_SEL_BW
)(
	input  logic                      clock_i,
	input  logic                      resetn_i,

	// write port, {field, entry}
	input  logic [ADDR_BW-1:0]        addr_i,
	input  logic                      wren_i,
	input  logic [31:0]               data_i,   // truncated to the field width

	// search port
	input  logic [WORD_ADDR_BW-1:0]   search_addr_i,
	output logic                      hit_o,
	output logic [LEASE_VALUE_BW-1:0] lease0_o,
	output logic [LEASE_VALUE_BW-1:0] lease1_o,
	output logic [PERCENT_BW-1:0]     lease0_prob_o
);

	logic [LLT_ENTRIES-1:0]    valid_q;
	logic [WORD_ADDR_BW-1:0]   ref_addr_q [LLT_ENTRIES];
	logic [LEASE_VALUE_BW-1:0] lease0_q   [LLT_ENTRIES];
	logic [LEASE_VALUE_BW-1:0] lease1_q   [LLT_ENTRIES];
	logic [PERCENT_BW-1:0]     prob_q     [LLT_ENTRIES];

	table_field_e              wr_field;
	logic [ENTRY_BW-1:0]       wr_entry;

	assign wr_field = table_field_e'(addr_i[ADDR_BW-1 -: TABLE_SEL_BW]);
	assign wr_entry = addr_i[ENTRY_BW-1:0];

	// write side
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0; // table starts empty
		end else if (wren_i && (wr_field == fld_ref_addr)) begin
			valid_q[wr_entry] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			case (wr_field)
				fld_ref_addr: ref_addr_q[wr_entry] <= data_i[WORD_ADDR_BW-1:0];
				fld_lease0:   lease0_q[wr_entry]   <= data_i[LEASE_VALUE_BW-1:0];
				fld_lease1:   lease1_q[wr_entry]   <= data_i[LEASE_VALUE_BW-1:0];
				fld_prob:     prob_q[wr_entry]     <= data_i[PERCENT_BW-1:0];
				default:      ;
			endcase
		end
	end

	// search side, lowest matching entry wins
	// ------------------------------------------------------------
	always_comb begin
		hit_o         = 1'b0;
		lease0_o      = '0;
		lease1_o      = '0;
		lease0_prob_o = '0;
		for (int i = LLT_ENTRIES - 1; i >= 0; i--) begin
			if (valid_q[i] && (ref_addr_q[i] == search_addr_i)) begin
				hit_o         = 1'b1;
				lease0_o      = lease0_q[i];
				lease1_o      = lease1_q[i];
				lease0_prob_o = prob_q[i];
			end
		end
	end

	// a write must land on a known field and entry
	wr_addr_known: assert property (@(posedge clock_i) disable iff (!resetn_i)
		wren_i |-> !$isunknown(addr_i));

endmodule

//--- source/priority_encoder.sv
/* one-hot to binary priority encoder, lowest (DIRECTION 0) or
   highest (DIRECTION 1) set bit wins */
`timescale 1ns/10ps

module priority_encoder #(
	parameter int  DIRECTION  = 0, // 0: lowest set bit, 1: highest set bit
	parameter int  INPUT_SIZE = 8,
	localparam int OUTPUT_BW  = (INPUT_SIZE > 1) ? $clog2(INPUT_SIZE) : 1
)(
	input  logic [INPUT_SIZE-1:0] encoding_i,
	output logic [OUTPUT_BW-1:0]  binary_o // zero when nothing is set
);

	always_comb begin
		binary_o = '0;
		if (DIRECTION == 0) begin
			// scan downward, last match is the lowest index
			for (int i = INPUT_SIZE - 1; i >= 0; i--) begin
				if (encoding_i[i]) begin
					binary_o = OUTPUT_BW'(i);
				end
			end
		end else begin
			// scan upward, last match is the highest index
			for (int i = 0; i < INPUT_SIZE; i++) begin
				if (encoding_i[i]) begin
					binary_o = OUTPUT_BW'(i);
				end
			end
		end
	end

endmodule

//--- source/lfsr_9b.sv
/* 9-bit maximal length fibonacci LFSR (x^9 + x^5 + 1),
   seeded on reset, shifts one step per enabled edge */
`timescale 1ns/10ps

module lfsr_9b #(
	parameter logic [8:0] SEED = 9'h1ff // must not be zero
)(
	input  logic       clock_i,
	input  logic       resetn_i,
	input  logic       enable_i, // advance one step
	output logic [8:0] result_o  // current pseudo-random value
);

	logic [8:0] state_q;
	logic       feedback;

	// taps at stages 9 and 5
	assign feedback = state_q[8] ^ state_q[4];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= SEED;
		end else if (enable_i) begin
			state_q <= {state_q[7:0], feedback}; // shift toward msb
		end
	end

	assign result_o = state_q;

endmodule

//--- source/lease_pkg.sv
/* widths, table field map and controller states shared by the lease
   replacement policy blocks */

package lease_pkg;

	// widths
	// ------------------------------------------------------------
	localparam int LEASE_VALUE_BW = 24; // lease value and per-line counter
	localparam int WORD_ADDR_BW   = 30; // word reference address
	localparam int PERCENT_BW     = 9;  // lease0 probability, 256 = always lease0
	localparam int TABLE_SEL_BW   = 2;  // upper llt address bits, pick the field

	// table fields, selected by the upper llt address bits
	typedef enum logic [TABLE_SEL_BW-1:0] {
		fld_ref_addr = 2'd0, // reference address, also marks the entry valid
		fld_lease0   = 2'd1, // preferred lease
		fld_lease1   = 2'd2, // alternate lease
		fld_prob     = 2'd3  // probability of lease0
	} table_field_e;

	// policy controller states
	// ------------------------------------------------------------
	typedef enum logic {
		st_normal,  // service hit and miss strobes
		st_gen_addr // produce a replacement line address
	} policy_state_e;

endpackage
